// ==== rtl/farm_pkg.sv ====
// Farm monitor shared definitions
package farm_pkg;

    // ==================================================
    // Widths and types
    // ==================================================
    typedef logic        [7:0]  pixel_t;   // Grayscale camera sample
    typedef logic        [7:0]  byte_t;    // UART byte
    typedef logic signed [7:0]  weight_t;  // Filter weight or bias
    typedef logic signed [23:0] acc_t;     // Filter accumulator
    typedef logic        [1:0]  level_t;   // Sensor level code
    typedef logic        [2:0]  alert_t;   // Alert severity

    // ==================================================
    // Classifier
    // ==================================================
    localparam int PIXEL_OFFSET  = 128;  // Centres pixel around zero
    localparam int NUM_FILTERS   = 8;
    localparam int KERNEL_PHASES = 8;    // Weights per filter, cycled per pixel
    localparam int VOTE_MAJORITY = 4;    // Non-negative filters for harvest

    // Row per filter, column per phase
    localparam weight_t CONV_WEIGHTS [NUM_FILTERS*KERNEL_PHASES] = '{
        -17,   35,  -39,   17,  -13,   39,  -11,    9,
          1,    9,   18,    2,   54,  -35,    8,  -86,
         10,    4,   -6,   22,    0,    7,    3,    5,
         14,   53,  -27,   16,  -78,   70,  -41,  127,
        -84,   22,  -47,   68,   27, -102,  -29,  111,
         14,  -93,   92,   29,  -40,  -10,  -42,  -47,
         48,   -5,  -72,  -49,   80,  -15,  -37,   59,
        -29,   66,  -61,   78,  -54,   20,   18,  -87
    };

    localparam weight_t CONV_BIASES [NUM_FILTERS] = '{
        -81, -39, -47, -127, -25, -111, -54, -81
    };

    // ==================================================
    // Sensor packet format
    // ==================================================
    localparam byte_t PKT_HEADER = 8'hAA;  // Start of packet

    // Byte positions after the header
    localparam logic [2:0] IDX_HEADER = 3'd0;
    localparam logic [2:0] IDX_TEMP   = 3'd1;
    localparam logic [2:0] IDX_HUMID  = 3'd2;
    localparam logic [2:0] IDX_LIGHT  = 3'd3;
    localparam logic [2:0] IDX_SOIL   = 3'd4;
    localparam logic [2:0] IDX_FAULT  = 3'd5;
    localparam logic [2:0] IDX_CSUM   = 3'd7;  // Byte 6 is actuator, summed only

    localparam level_t LEVEL_OPTIMAL = 2'd2;

    // ==================================================
    // Alert codes
    // ==================================================
    localparam alert_t ALERT_FAULT      = 3'd7;  // Any co-processor fault
    localparam alert_t ALERT_HARVEST    = 3'd6;  // Camera and sensors agree
    localparam alert_t ALERT_CNN_ONLY   = 3'd4;
    localparam alert_t ALERT_SUBOPTIMAL = 3'd2;
    localparam alert_t ALERT_NORMAL     = 3'd0;

endpackage

// ==== rtl/camera_capture.sv ====
// Camera bus capture
`timescale 1ns/100ps

module camera_capture (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cam_href,
    input  logic             cam_vsync,
    input  farm_pkg::pixel_t cam_data,
    output farm_pkg::pixel_t pixel,
    output logic             pixel_valid,
    output logic             frame_start
);

    logic vsync_d;  // Previous vsync for edge detect

    // Control flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
            vsync_d     <= 1'b0;
        end else begin
            vsync_d     <= cam_vsync;
            frame_start <= cam_vsync && !vsync_d;  // Rising edge only
            pixel_valid <= cam_href;               // Follows href by one cycle
        end
    end

    // Pixel data held between active lines
    always_ff @(posedge clk) begin
        if (cam_href) begin
            pixel <= cam_data;
        end
    end

endmodule

// ==== rtl/frame_classifier.sv ====
// Streaming frame classifier
`timescale 1ns/100ps

module frame_classifier #(
    parameter int FRAME_PIXELS = 512  // Multiple of KERNEL_PHASES
) (
    input  logic             clk,
    input  logic             rst_n,
    input  farm_pkg::pixel_t pixel,
    input  logic             pixel_valid,
    input  logic             frame_start,
    output logic             cnn_harvest,
    output logic             cnn_ready
);

    localparam int CNT_W   = $clog2(FRAME_PIXELS + 1);
    localparam int PHASE_W = $clog2(farm_pkg::KERNEL_PHASES);
    localparam int VOTE_W  = $clog2(farm_pkg::NUM_FILTERS + 1);

    logic [CNT_W-1:0]   pix_cnt;   // Pixels taken this frame
    logic [PHASE_W-1:0] phase;     // Kernel position
    logic               frame_full;
    logic               accept;
    logic signed [8:0]  px_c;      // Centred pixel
    logic signed [16:0] prod  [farm_pkg::NUM_FILTERS];
    farm_pkg::acc_t     acc   [farm_pkg::NUM_FILTERS];
    logic [VOTE_W-1:0]  votes;

    // Frame length is a multiple of the phase count, so the phase is the count's low bits
    assign phase      = pix_cnt[PHASE_W-1:0];
    assign frame_full = (pix_cnt == CNT_W'(FRAME_PIXELS));
    assign accept     = pixel_valid && !frame_full;

    // ==================================================
    // Multiply stage
    // ==================================================
    always_comb begin
        px_c = {1'b0, pixel} - 9'(farm_pkg::PIXEL_OFFSET);
        for (int f = 0; f < farm_pkg::NUM_FILTERS; f++) begin
            // One weight per filter, row f of the table
            prod[f] = px_c * farm_pkg::CONV_WEIGHTS[f*farm_pkg::KERNEL_PHASES + int'(phase)];
        end
    end

    // Majority vote over the filter signs
    always_comb begin
        votes = '0;
        for (int f = 0; f < farm_pkg::NUM_FILTERS; f++) begin
            if (acc[f] >= 0) begin
                votes = votes + 1'b1;
            end
        end
    end

    // ==================================================
    // Accumulate and decide
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt     <= '0;
            cnn_ready   <= 1'b0;
            cnn_harvest <= 1'b0;
            for (int f = 0; f < farm_pkg::NUM_FILTERS; f++) begin
                acc[f] <= '0;
            end
        end else if (frame_start) begin
            pix_cnt   <= '0;
            cnn_ready <= 1'b0;  // Result stale until frame ends
            for (int f = 0; f < farm_pkg::NUM_FILTERS; f++) begin
                acc[f] <= farm_pkg::CONV_BIASES[f];  // Sign extended
            end
        end else if (accept) begin
            pix_cnt <= pix_cnt + 1'b1;
            for (int f = 0; f < farm_pkg::NUM_FILTERS; f++) begin
                acc[f] <= acc[f] + prod[f];
            end
        end else if (frame_full && !cnn_ready) begin
            // Count reached, latch the vote once
            cnn_ready   <= 1'b1;
            cnn_harvest <= (votes >= VOTE_W'(farm_pkg::VOTE_MAJORITY));
        end
    end

endmodule

// ==== rtl/uart_receiver.sv ====
// UART 8N1 receiver
`timescale 1ns/100ps

module uart_receiver #(
    parameter int CLKS_PER_BIT = 868  // Clock cycles per bit
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,
    output farm_pkg::byte_t rx_byte,
    output logic            rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_DATA  = 2'd2;
    localparam logic [1:0] S_STOP  = 2'd3;

    logic             rx_meta;
    logic             rx_sync;
    logic [1:0]       state;
    logic [CNT_W-1:0] clk_cnt;  // Cycles within current bit
    logic [2:0]       bit_idx;
    farm_pkg::byte_t  shift_reg;
    logic             mid_bit;
    logic             bit_done;

    assign mid_bit  = (clk_cnt == CNT_W'((CLKS_PER_BIT - 1) / 2));
    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ==================================================
    // Receive FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;  // Single-cycle pulse
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= S_START;  // Falling edge
                end
                S_START: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;  // Glitch rejected
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end
                end
                default: begin  // S_STOP
                    if (bit_done) begin
                        rx_valid <= rx_sync;  // Framing error drops the byte
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Data path, LSB first
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_done) shift_reg <= {rx_sync, shift_reg[7:1]};
        if (state == S_STOP && bit_done && rx_sync) rx_byte <= shift_reg;
    end

endmodule

// ==== rtl/sensor_packet_parser.sv ====
// Sensor packet parser
`timescale 1ns/100ps

module sensor_packet_parser (
    input  logic             clk,
    input  logic             rst_n,
    input  farm_pkg::byte_t  rx_byte,
    input  logic             rx_valid,
    output farm_pkg::level_t temp,
    output farm_pkg::level_t humidity,
    output farm_pkg::level_t light,
    output farm_pkg::level_t soil,
    output farm_pkg::byte_t  fault_flags
);

    logic [2:0]       byte_idx;  // Position in packet, 0 while hunting
    farm_pkg::byte_t  csum;      // Running sum of data bytes
    farm_pkg::level_t temp_s;
    farm_pkg::level_t humid_s;
    farm_pkg::level_t light_s;
    farm_pkg::level_t soil_s;
    farm_pkg::byte_t  fault_s;
    logic             pkt_good;

    assign pkt_good = rx_valid && (byte_idx == farm_pkg::IDX_CSUM) && (rx_byte == csum);

    // ==================================================
    // Byte sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx <= farm_pkg::IDX_HEADER;
        end else if (rx_valid) begin
            if (byte_idx == farm_pkg::IDX_HEADER) begin
                if (rx_byte == farm_pkg::PKT_HEADER) byte_idx <= farm_pkg::IDX_TEMP;
            end else if (byte_idx == farm_pkg::IDX_CSUM) begin
                byte_idx <= farm_pkg::IDX_HEADER;  // Back to hunting, good or bad
            end else begin
                byte_idx <= byte_idx + 3'd1;
            end
        end
    end

    // Shadow fields and checksum
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (byte_idx)
                farm_pkg::IDX_HEADER: csum <= '0;
                farm_pkg::IDX_TEMP:   temp_s  <= rx_byte[1:0];
                farm_pkg::IDX_HUMID:  humid_s <= rx_byte[1:0];
                farm_pkg::IDX_LIGHT:  light_s <= rx_byte[1:0];
                farm_pkg::IDX_SOIL:   soil_s  <= rx_byte[1:0];
                farm_pkg::IDX_FAULT:  fault_s <= rx_byte;
                default: ;             // Actuator byte and checksum
            endcase
            if (byte_idx != farm_pkg::IDX_HEADER && byte_idx != farm_pkg::IDX_CSUM) begin
                csum <= csum + rx_byte;  // Low 8 bits kept
            end
        end
    end

    // ==================================================
    // Commit on matching checksum
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            temp        <= '0;
            humidity    <= '0;
            light       <= '0;
            soil        <= '0;
            fault_flags <= '0;
        end else if (pkt_good) begin
            temp        <= temp_s;
            humidity    <= humid_s;
            light       <= light_s;
            soil        <= soil_s;
            fault_flags <= fault_s;
        end
    end

endmodule

// ==== rtl/harvest_decision.sv ====
// Harvest decision fusion
`timescale 1ns/100ps

module harvest_decision (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cnn_harvest,
    input  logic             cnn_ready,
    input  farm_pkg::level_t temp,
    input  farm_pkg::level_t humidity,
    input  farm_pkg::level_t light,
    input  farm_pkg::level_t soil,
    input  farm_pkg::byte_t  fault_flags,
    output logic             harvest_alert,
    output farm_pkg::alert_t alert_level,
    output logic             fault_detected
);

    logic cnn_flag;   // Last frame vote
    logic sensor_ok;  // All four levels optimal
    logic any_fault;

    assign any_fault      = |fault_flags;
    assign fault_detected = any_fault;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnn_flag      <= 1'b0;
            sensor_ok     <= 1'b0;
            harvest_alert <= 1'b0;
            alert_level   <= farm_pkg::ALERT_NORMAL;
        end else begin
            if (cnn_ready) cnn_flag <= cnn_harvest;  // Held between frames

            sensor_ok <= (temp == farm_pkg::LEVEL_OPTIMAL) &&
                         (humidity == farm_pkg::LEVEL_OPTIMAL) &&
                         (light == farm_pkg::LEVEL_OPTIMAL) &&
                         (soil == farm_pkg::LEVEL_OPTIMAL);

            harvest_alert <= cnn_flag && sensor_ok;  // Both sources agree

            // Highest severity wins
            if (any_fault) begin
                alert_level <= farm_pkg::ALERT_FAULT;
            end else if (cnn_flag && sensor_ok) begin
                alert_level <= farm_pkg::ALERT_HARVEST;
            end else if (cnn_flag) begin
                alert_level <= farm_pkg::ALERT_CNN_ONLY;
            end else if (!sensor_ok) begin
                alert_level <= farm_pkg::ALERT_SUBOPTIMAL;
            end else begin
                alert_level <= farm_pkg::ALERT_NORMAL;
            end
        end
    end

endmodule

// ==== rtl/farm_monitor_top.sv ====
// Precision farming monitor top level
`timescale 1ns/100ps

module farm_monitor_top #(
    parameter int CLKS_PER_BIT = 868,  // UART bit period in clocks
    parameter int FRAME_PIXELS = 512   // Pixels per camera frame
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cam_href,
    input  logic             cam_vsync,
    input  farm_pkg::pixel_t cam_data,
    input  logic             uart_rx,
    output logic             harvest_alert,
    output farm_pkg::alert_t alert_level,
    output logic             fault_detected
);

    // ==================================================
    // Internal nets
    // ==================================================
    farm_pkg::pixel_t pixel;
    logic             pixel_valid;
    logic             frame_start;
    logic             cnn_harvest;
    logic             cnn_ready;
    farm_pkg::byte_t  rx_byte;
    logic             rx_valid;
    farm_pkg::level_t temp;
    farm_pkg::level_t humidity;
    farm_pkg::level_t light;
    farm_pkg::level_t soil;
    farm_pkg::byte_t  fault_flags;

    // Camera path
    camera_capture i_camera_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .cam_href    (cam_href),
        .cam_vsync   (cam_vsync),
        .cam_data    (cam_data),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start)
    );

    frame_classifier #(.FRAME_PIXELS(FRAME_PIXELS)) i_frame_classifier (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start),
        .cnn_harvest (cnn_harvest),
        .cnn_ready   (cnn_ready)
    );

    // Sensor path from co-processor
    uart_receiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_receiver (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    sensor_packet_parser i_sensor_packet_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .temp        (temp),
        .humidity    (humidity),
        .light       (light),
        .soil        (soil),
        .fault_flags (fault_flags)
    );

    // Fusion and alerts
    harvest_decision i_harvest_decision (
        .clk            (clk),
        .rst_n          (rst_n),
        .cnn_harvest    (cnn_harvest),
        .cnn_ready      (cnn_ready),
        .temp           (temp),
        .humidity       (humidity),
        .light          (light),
        .soil           (soil),
        .fault_flags    (fault_flags),
        .harvest_alert  (harvest_alert),
        .alert_level    (alert_level),
        .fault_detected (fault_detected)
    );

endmodule

// ==== testbench/tb_farm_monitor.sv ====
// Farm monitor testbench
`timescale 1ns/100ps

module tb_farm_monitor;

    localparam int BIT_CLKS   = 16;   // UART bit period in clocks
    localparam int FRAME_PX   = 64;   // Pixels per frame
    localparam int BLANK_CLKS = 8;    // Vertical blanking after the last pixel
    localparam int STEP_WORDS = 12;   // Kind, eight bytes, three expected values
    localparam int MAX_STEPS  = 32;
    localparam int WAIT_LIMIT = 200;  // Cycles allowed for an output to settle

    localparam logic [7:0] KIND_END    = 8'h00;
    localparam logic [7:0] KIND_PACKET = 8'h01;
    localparam logic [7:0] KIND_FRAME  = 8'h02;
    localparam logic [7:0] KIND_NOISY  = 8'h03;  // Noise bytes, then a packet

    logic             clk;
    logic             rst_n;
    logic             cam_href;
    logic             cam_vsync;
    farm_pkg::pixel_t cam_data;
    logic             uart_rx;
    logic             harvest_alert;
    farm_pkg::alert_t alert_level;
    logic             fault_detected;

    logic [7:0] stim_mem [MAX_STEPS*STEP_WORDS];  // One row of words per step
    int         pass_count;
    int         fail_count;

    farm_monitor_top #(
        .CLKS_PER_BIT (BIT_CLKS),
        .FRAME_PIXELS (FRAME_PX)
    ) i_farm_monitor_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .cam_href       (cam_href),
        .cam_vsync      (cam_vsync),
        .cam_data       (cam_data),
        .uart_rx        (uart_rx),
        .harvest_alert  (harvest_alert),
        .alert_level    (alert_level),
        .fault_detected (fault_detected)
    );

    always #10 clk = ~clk;  // 20 ns period

    // ==================================================
    // Stimulus drivers, all on the falling edge
    // ==================================================
    task automatic send_byte(input farm_pkg::byte_t b);
        int gap;
        uart_rx = 1'b0;  // Start bit
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];  // LSB first
            repeat (BIT_CLKS) @(negedge clk);
        end
        uart_rx = 1'b1;  // Stop bit
        repeat (BIT_CLKS) @(negedge clk);
        gap = $urandom_range(0, 7);  // Idle line between bytes
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_packet(input int base, input logic noisy);
        if (noisy) begin
            // Below 0x80, so never mistaken for the header
            repeat (3) send_byte(farm_pkg::byte_t'($urandom_range(0, 127)));
        end
        for (int i = 1; i <= 8; i++) begin
            send_byte(stim_mem[base+i]);
        end
    endtask

    task automatic send_frame(input farm_pkg::pixel_t px);
        int gap;
        cam_vsync = 1'b1;  // Frame start
        repeat (2) @(negedge clk);
        cam_vsync = 1'b0;
        repeat (2) @(negedge clk);
        for (int n = 0; n < FRAME_PX; n++) begin
            cam_href = 1'b1;
            cam_data = px;
            @(negedge clk);
            cam_href = 1'b0;
            cam_data = farm_pkg::pixel_t'($urandom);  // Junk while href low
            gap = $urandom_range(0, 3);
            repeat (gap) @(negedge clk);
        end
        cam_href = 1'b0;
        repeat (BLANK_CLKS) @(negedge clk);  // Vote reaches the outputs in blanking
    endtask

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic expect_flag(input string name, input logic use_fault,
                               input logic expected, output logic ok);
        logic actual;
        int   waited;
        waited = 0;
        actual = use_fault ? fault_detected : harvest_alert;
        while (actual !== expected && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
            actual = use_fault ? fault_detected : harvest_alert;
        end
        ok = (actual === expected);
        if (!ok) $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
    endtask

    task automatic expect_alert(input farm_pkg::alert_t expected, output logic ok);
        int waited;
        waited = 0;
        while (alert_level !== expected && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = (alert_level === expected);
        if (!ok) begin
            $display("Fail at %0t ns: alert_level is %0d, expected %0d",
                     $time, alert_level, expected);
        end
    endtask

    task automatic log_step_result(input int step, input string what, input logic ok);
        if (ok) begin
            pass_count++;
            $display("step %0d %s: ok", step, what);
        end else begin
            fail_count++;
            $display("step %0d %s: mismatch", step, what);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int               step;
        int               base;
        logic             ok_h;
        logic             ok_a;
        logic             ok_f;
        farm_pkg::alert_t exp_alert;
        string            what;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cam_href   = 1'b0;
        cam_vsync  = 1'b0;
        cam_data   = '0;
        uart_rx    = 1'b1;  // Line idles high
        pass_count = 0;
        fail_count = 0;
        void'($urandom(62570));
        $readmemh("testbench/farm_stimulus.txt", stim_mem);

        // Reset values, checked while reset is held
        repeat (4) @(negedge clk);
        expect_flag("harvest_alert", 1'b0, 1'b0, ok_h);
        expect_alert(farm_pkg::ALERT_NORMAL, ok_a);
        expect_flag("fault_detected", 1'b1, 1'b0, ok_f);
        log_step_result(0, "reset", ok_h && ok_a && ok_f);
        rst_n = 1'b1;

        step = 0;
        while (step < MAX_STEPS && stim_mem[step*STEP_WORDS] != KIND_END) begin
            base = step * STEP_WORDS;
            case (stim_mem[base])
                KIND_PACKET: begin
                    what = "packet";
                    send_packet(base, 1'b0);
                end
                KIND_NOISY: begin
                    what = "noisy packet";
                    send_packet(base, 1'b1);
                end
                KIND_FRAME: begin
                    what = "frame";
                    send_frame(stim_mem[base+1]);
                end
                default: begin
                    what = "unknown";
                    $display("Step %0d has an unknown kind %h in the stimulus file",
                             step + 1, stim_mem[base]);
                end
            endcase
            exp_alert = stim_mem[base+10][2:0];
            expect_flag("harvest_alert", 1'b0, stim_mem[base+9][0], ok_h);
            expect_alert(exp_alert, ok_a);
            expect_flag("fault_detected", 1'b1, stim_mem[base+11][0], ok_f);
            log_step_result(step + 1, what, ok_h && ok_a && ok_f && what != "unknown");
            step++;
        end

        if (step == 0) begin
            $display("The stimulus file gave no steps to run");
            fail_count++;
        end

        $display("Steps passed: %0d, steps failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/farm_stimulus.txt ====
// kind (01 packet, 02 frame, 03 noise then packet, 00 end), eight bytes (packet or pixel),
// then expected harvest_alert, alert_level, fault_detected
01 AA 02 02 02 02 00 00 08 00 00 00
02 80 00 00 00 00 00 00 00 00 00 00
01 AA 02 02 01 02 00 00 07 00 02 00
02 FF 00 00 00 00 00 00 00 00 04 00
01 AA 02 02 02 02 00 00 08 01 06 00
01 AA 02 02 02 02 04 00 0C 01 07 01
01 AA 01 01 01 01 00 00 FF 01 07 01
01 AA 02 02 02 02 00 5A 62 01 06 00
03 AA 02 03 02 02 00 00 09 00 04 00
02 80 00 00 00 00 00 00 00 00 02 00
01 AA 01 01 01 01 80 00 84 00 07 01
00 00 00 00 00 00 00 00 00 00 00 00

// ==== vlog.f ====
rtl/farm_pkg.sv
rtl/camera_capture.sv
rtl/frame_classifier.sv
rtl/uart_receiver.sv
rtl/sensor_packet_parser.sv
rtl/harvest_decision.sv
rtl/farm_monitor_top.sv
testbench/tb_farm_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the farm monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_farm_monitor -f vlog.f -o sim_farm_monitor

out=$(./obj_dir/sim_farm_monitor)
echo "$out"
echo "$out" | grep -qx 'STATUS: PASS'
